// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN = 32;

  // major opcodes kept by this core
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_REG_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG_REG = 7'b0110011;
  localparam logic [6:0] OP_BRANCH  = 7'b1100011;
  localparam logic [6:0] OP_ENVIRON = 7'b1110011;

  // funct3 for the alu groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // selects sub and the arithmetic right shifts
  localparam logic [6:0] F7_ALT = 7'b0100000;

  localparam logic [3:0] ALU_ADD    = 4'd0;
  localparam logic [3:0] ALU_SUB    = 4'd1;
  localparam logic [3:0] ALU_SLL    = 4'd2;
  localparam logic [3:0] ALU_SLT    = 4'd3;
  localparam logic [3:0] ALU_SLTU   = 4'd4;
  localparam logic [3:0] ALU_XOR    = 4'd5;
  localparam logic [3:0] ALU_SRL    = 4'd6;
  localparam logic [3:0] ALU_SRA    = 4'd7;
  localparam logic [3:0] ALU_OR     = 4'd8;
  localparam logic [3:0] ALU_AND    = 4'd9;
  localparam logic [3:0] ALU_PASS_B = 4'd10;

  // one instruction word, four views of its fields
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } rv_insn_t;

endpackage

// File: src/core_cfg_pkg.sv
package core_cfg_pkg;

  // architectural register file
  localparam int NUM_REGS   = 32;
  localparam int REG_ADDR_W = 5;

  // first fetch address after reset
  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  // byte distance between sequential instructions
  localparam int unsigned PC_STEP = 4;

endpackage

// File: src/core_ifs.sv
interface decode_if;
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic                  rd_we;
  logic [3:0]            alu_op;
  logic                  use_imm;
  logic [XLEN-1:0]       imm;
  logic                  is_branch;
  logic [2:0]            br_funct3;
  logic                  is_ecall;
  logic                  is_illegal;

  modport src (
    output rs1, rs2, rd, rd_we, alu_op, use_imm, imm,
    output is_branch, br_funct3, is_ecall, is_illegal
  );
  modport alu_side (input alu_op, use_imm, imm, br_funct3);
  modport rf_side (input rs1, rs2, rd_we);
  modport pc_side (input rd, rd_we, imm, is_branch, is_ecall, is_illegal);
endinterface

interface wb_if;
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  logic                  accept;
  logic [REG_ADDR_W-1:0] rd;
  logic                  rd_we;
  logic [XLEN-1:0]       data;

  modport source (output accept, rd, rd_we);
  modport sink (input accept, rd, rd_we, data);
endinterface

// File: src/insn_decode.sv
module insn_decode (
  input rv_isa_pkg::rv_insn_t insn,
  decode_if.src               dec
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic            f7_zero;
  logic            f7_alt;
  logic            we;
  logic            bad;

  // shared funct3 map of the two alu groups
  function automatic logic [3:0] f3_to_op(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  assign imm_i = {{(XLEN-12){insn.i.imm_11_0[11]}}, insn.i.imm_11_0};
  assign imm_b = {{(XLEN-13){insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm_31_12, 12'b0};

  assign f7_zero = insn.r.funct7 == 7'b0;
  assign f7_alt  = insn.r.funct7 == F7_ALT;

  always_comb begin
    dec.rs1       = insn.r.rs1;
    dec.rs2       = insn.r.rs2;
    dec.rd        = insn.r.rd;
    dec.alu_op    = ALU_ADD;
    dec.use_imm   = 1'b0;
    dec.imm       = '0;
    dec.is_branch = 1'b0;
    dec.br_funct3 = insn.b.funct3;
    dec.is_ecall  = 1'b0;
    we            = 1'b0;
    bad           = 1'b0;
    case (insn.r.opcode)
      OP_LUI: begin
        we          = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = imm_u;
        dec.alu_op  = ALU_PASS_B;
      end
      OP_REG_IMM: begin
        we          = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = imm_i;
        // upper imm bits are funct7 only for the shifts
        if (insn.i.funct3 == F3_SLL) begin
          bad = !f7_zero;
        end else if (insn.i.funct3 == F3_SRL_SRA) begin
          bad = !(f7_zero || f7_alt);
        end
        dec.alu_op = f3_to_op(insn.i.funct3, insn.i.funct3 == F3_SRL_SRA && f7_alt);
      end
      OP_REG_REG: begin
        we         = 1'b1;
        dec.alu_op = f3_to_op(insn.r.funct3, f7_alt);
        bad = !(f7_zero || (f7_alt && (insn.r.funct3 == F3_ADD_SUB ||
                                       insn.r.funct3 == F3_SRL_SRA)));
      end
      OP_BRANCH: begin
        dec.is_branch = 1'b1;
        dec.imm       = imm_b;
        // funct3 010 and 011 are unused
        bad = insn.b.funct3[2:1] == 2'b01;
      end
      OP_ENVIRON: begin
        if (insn.i.imm_11_0 == '0 && insn.i.rs1 == '0 && insn.i.funct3 == '0 &&
            insn.i.rd == '0) begin
          dec.is_ecall = 1'b1;
        end else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase
  end

  // an illegal word never writes the register file
  assign dec.rd_we      = we && !bad;
  assign dec.is_illegal = bad;

endmodule

// File: src/alu.sv
module alu (
  decode_if.alu_side                  dec,
  input  logic [rv_isa_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_isa_pkg::XLEN-1:0] rs2_data,
  output logic [rv_isa_pkg::XLEN-1:0] wb_data,
  output logic                        branch_taken
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] add_b;
  logic [XLEN-1:0] sum;
  logic            is_sub;
  logic [4:0]      shamt;
  logic            eq;
  logic            lt;
  logic            ltu;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  // one adder for add and sub, two's complement via carry in
  assign is_sub = dec.alu_op == ALU_SUB;
  assign add_b  = is_sub ? ~op_b : op_b;
  assign sum    = rs1_data + add_b + XLEN'(is_sub);

  always_comb begin
    case (dec.alu_op)
      ALU_ADD, ALU_SUB: wb_data = sum;
      ALU_SLL:    wb_data = rs1_data << shamt;
      ALU_SLT:    wb_data = XLEN'($signed(rs1_data) < $signed(op_b));
      ALU_SLTU:   wb_data = XLEN'(rs1_data < op_b);
      ALU_XOR:    wb_data = rs1_data ^ op_b;
      ALU_SRL:    wb_data = rs1_data >> shamt;
      ALU_SRA:    wb_data = $unsigned($signed(rs1_data) >>> shamt);
      ALU_OR:     wb_data = rs1_data | op_b;
      ALU_AND:    wb_data = rs1_data & op_b;
      ALU_PASS_B: wb_data = op_b;
      default:    wb_data = '0;
    endcase
  end

  // branch compare always works on the two registers
  assign eq  = rs1_data == rs2_data;
  assign lt  = $signed(rs1_data) < $signed(rs2_data);
  assign ltu = rs1_data < rs2_data;

  always_comb begin
    case (dec.br_funct3)
      F3_BEQ:  branch_taken = eq;
      F3_BNE:  branch_taken = !eq;
      F3_BLT:  branch_taken = lt;
      F3_BGE:  branch_taken = !lt;
      F3_BLTU: branch_taken = ltu;
      F3_BGEU: branch_taken = !ltu;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// File: src/reg_file.sv
module reg_file (
  input  logic                              clk,
  input  logic                              rst,
  decode_if.rf_side                         dec,
  wb_if.sink                                wb,
  output logic [rv_isa_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0]       rs2_data,
  output logic                              retire_valid,
  output logic                              retire_rd_we,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic [rv_isa_pkg::XLEN-1:0]       retire_data
);
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  assign rs1_data = regs[dec.rs1];
  assign rs2_data = regs[dec.rs2];

  // x0 is never written, so it stays at its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.accept && dec.rd_we && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= wb.accept;
    end
  end

  // retire report, one cycle behind the accept
  always_ff @(posedge clk) begin
    if (wb.accept) begin
      retire_rd_we <= wb.rd_we;
      retire_rd    <= wb.rd;
      retire_data  <= wb.data;
    end
  end

  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    dec.rs1 == '0 |-> rs1_data == '0);

endmodule

// File: src/pc_unit.sv
module pc_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        insn_valid,
  output logic                        insn_ready,
  decode_if.pc_side                   dec,
  input  logic                        branch_taken,
  wb_if.source                        wb,
  output logic [rv_isa_pkg::XLEN-1:0] fetch_pc,
  output logic                        halt,
  output logic                        illegal
);
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_incr;
  logic            running;
  logic            stop;

  assign insn_ready = running;
  assign wb.accept  = insn_valid && running;
  assign wb.rd      = dec.rd;
  assign wb.rd_we   = dec.rd_we;

  assign stop    = dec.is_ecall || dec.is_illegal;
  assign pc_incr = (dec.is_branch && branch_taken) ? dec.imm : XLEN'(PC_STEP);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= RESET_PC;
      running <= 1'b0;
      halt    <= 1'b0;
      illegal <= 1'b0;
    end else begin
      if (wb.accept) begin
        pc <= pc + pc_incr;
      end
      // stopped until the next reset
      if (wb.accept && stop) begin
        running <= 1'b0;
        halt    <= 1'b1;
        illegal <= dec.is_illegal;
      end else if (!halt) begin
        running <= 1'b1;
      end
    end
  end

  assign fetch_pc = pc;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) fetch_pc[1:0] == 2'b00);

  a_no_ready_halted: assert property (@(posedge clk) disable iff (rst)
    !(insn_ready && halt));

endmodule

// File: src/rv_core.sv
module rv_core (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                insn_valid,
  input  logic [rv_isa_pkg::XLEN-1:0]         insn,
  output logic                                insn_ready,
  output logic [rv_isa_pkg::XLEN-1:0]         fetch_pc,
  output logic                                retire_valid,
  output logic                                retire_rd_we,
  output logic [core_cfg_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic [rv_isa_pkg::XLEN-1:0]         retire_data,
  output logic                                halt,
  output logic                                illegal
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            branch_taken;

  decode_if dec ();
  wb_if     wb ();

  insn_decode u_decode (
    .insn (insn),
    .dec  (dec)
  );

  alu u_alu (
    .dec          (dec),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .wb_data      (wb.data),
    .branch_taken (branch_taken)
  );

  reg_file u_regs (
    .clk          (clk),
    .rst          (rst),
    .dec          (dec),
    .wb           (wb),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .retire_valid (retire_valid),
    .retire_rd_we (retire_rd_we),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  pc_unit u_pc (
    .clk          (clk),
    .rst          (rst),
    .insn_valid   (insn_valid),
    .insn_ready   (insn_ready),
    .dec          (dec),
    .branch_taken (branch_taken),
    .wb           (wb),
    .fetch_pc     (fetch_pc),
    .halt         (halt),
    .illegal      (illegal)
  );

endmodule

// File: bench/clk_gen.sv
module clk_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // power-on reset for 10 cycles
  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  end
endmodule

// File: bench/tb_rv_core.sv
module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT     = 20;
  localparam int END_NONE    = 0;
  localparam int END_HALT    = 1;
  localparam int END_ILLEGAL = 2;

  typedef struct {
    logic [31:0] pc;
    logic [31:0] word;
    int          we;
    int          rd;
    logic [31:0] data;
    int          ends;
  } row_t;

  logic        clk;
  logic        por_rst;
  logic        tb_rst;
  logic        rst;
  logic        insn_valid;
  logic [31:0] insn;
  logic        insn_ready;
  logic [31:0] fetch_pc;
  logic        retire_valid;
  logic        retire_rd_we;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        halt;
  logic        illegal;

  row_t rows[$];
  int   errors;
  int   checks;
  bit   stop_run;

  assign rst = por_rst | tb_rst;

  clk_gen u_clk (
    .clk (clk),
    .rst (por_rst)
  );

  rv_core DUT (
    .clk          (clk),
    .rst          (rst),
    .insn_valid   (insn_valid),
    .insn         (insn),
    .insn_ready   (insn_ready),
    .fetch_pc     (fetch_pc),
    .retire_valid (retire_valid),
    .retire_rd_we (retire_rd_we),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halt         (halt),
    .illegal      (illegal)
  );

  // small assemblers for the instruction table
  function automatic logic [31:0] r_type(input int f7, rs2, rs1, f3, rd);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input int imm, rs1, f3, rd);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'b0010011};
  endfunction

  function automatic logic [31:0] b_type(input int off, rs2, rs1, f3);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
  endfunction

  task automatic add_row(input logic [31:0] pc, word, input int we, rd,
                         input logic [31:0] data, input int ends);
    row_t r;
    r = '{pc, word, we, rd, data, ends};
    rows.push_back(r);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic build_table();
    // lui and register-immediate, f3 codes as in RV32I
    add_row('h00, 32'h800000b7, 1, 1, 32'h80000000, END_NONE);
    add_row('h04, i_type(-5, 0, 0, 2), 1, 2, 32'hfffffffb, END_NONE);
    add_row('h08, i_type(1, 2, 2, 3), 1, 3, 32'h1, END_NONE);
    add_row('h0c, i_type(1, 2, 3, 4), 1, 4, 32'h0, END_NONE);
    add_row('h10, i_type(-1, 0, 3, 5), 1, 5, 32'h1, END_NONE);
    add_row('h14, i_type(-1, 0, 2, 6), 1, 6, 32'h0, END_NONE);
    add_row('h18, i_type('h404, 1, 5, 7), 1, 7, 32'hf8000000, END_NONE);
    add_row('h1c, i_type(4, 1, 5, 8), 1, 8, 32'h08000000, END_NONE);
    add_row('h20, i_type(3, 2, 1, 9), 1, 9, 32'hffffffd8, END_NONE);
    add_row('h24, i_type('h0f0, 2, 4, 10), 1, 10, 32'hffffff0b, END_NONE);
    add_row('h28, i_type('h555, 0, 6, 11), 1, 11, 32'h555, END_NONE);
    add_row('h2c, i_type('h07f, 2, 7, 12), 1, 12, 32'h7b, END_NONE);
    // write to x0 reports the data, then x0 still reads as zero
    add_row('h30, i_type(123, 0, 0, 0), 1, 0, 32'd123, END_NONE);
    add_row('h34, r_type(0, 0, 0, 0, 13), 1, 13, 32'h0, END_NONE);
    add_row('h38, 32'h12345737, 1, 14, 32'h12345000, END_NONE);
    // register-register on earlier results
    add_row('h3c, r_type('h20, 2, 11, 0, 15), 1, 15, 32'h55a, END_NONE);
    add_row('h40, r_type(0, 11, 14, 0, 16), 1, 16, 32'h12345555, END_NONE);
    add_row('h44, r_type(0, 3, 11, 1, 17), 1, 17, 32'haaa, END_NONE);
    add_row('h48, r_type(0, 5, 1, 5, 18), 1, 18, 32'h40000000, END_NONE);
    add_row('h4c, r_type('h20, 5, 1, 5, 19), 1, 19, 32'hc0000000, END_NONE);
    add_row('h50, r_type(0, 11, 2, 2, 20), 1, 20, 32'h1, END_NONE);
    add_row('h54, r_type(0, 11, 2, 3, 21), 1, 21, 32'h0, END_NONE);
    add_row('h58, r_type(0, 16, 14, 4, 22), 1, 22, 32'h555, END_NONE);
    add_row('h5c, r_type(0, 11, 1, 6, 23), 1, 23, 32'h80000555, END_NONE);
    add_row('h60, r_type(0, 11, 2, 7, 24), 1, 24, 32'h551, END_NONE);
    // each branch taken, then not taken
    add_row('h64, b_type(8, 11, 22, 0), 0, 0, 32'h0, END_NONE);
    add_row('h6c, b_type(8, 4, 3, 0), 0, 0, 32'h0, END_NONE);
    add_row('h70, b_type(12, 4, 3, 1), 0, 0, 32'h0, END_NONE);
    add_row('h7c, b_type(8, 11, 22, 1), 0, 0, 32'h0, END_NONE);
    add_row('h80, b_type(16, 3, 2, 4), 0, 0, 32'h0, END_NONE);
    add_row('h90, b_type(8, 2, 3, 4), 0, 0, 32'h0, END_NONE);
    add_row('h94, b_type(-16, 2, 3, 5), 0, 0, 32'h0, END_NONE);
    add_row('h84, b_type(8, 3, 2, 5), 0, 0, 32'h0, END_NONE);
    add_row('h88, b_type(32, 2, 3, 6), 0, 0, 32'h0, END_NONE);
    add_row('ha8, b_type(8, 3, 2, 6), 0, 0, 32'h0, END_NONE);
    add_row('hac, b_type(8, 3, 2, 7), 0, 0, 32'h0, END_NONE);
    add_row('hb4, b_type(8, 3, 4, 7), 0, 0, 32'h0, END_NONE);
    add_row('hb8, 32'h00000073, 0, 0, 32'h0, END_HALT);
    // second run, a load word is outside the kept set
    add_row('h00, 32'h00002083, 0, 0, 32'h0, END_ILLEGAL);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rst) begin
      $display("reset still asserted after %0d cycles at %0t", TIMEOUT, $time);
      errors++;
      stop_run = 1'b1;
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!insn_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!insn_ready) begin
      $display("insn_ready stayed low for %0d cycles at %0t", TIMEOUT, $time);
      errors++;
      stop_run = 1'b1;
    end
  endtask

  task automatic check_reset_state();
    check_word("fetch_pc", fetch_pc, 32'h0);
    check_bit("retire_valid", retire_valid, 1'b0);
    check_bit("halt", halt, 1'b0);
    check_bit("illegal", illegal, 1'b0);
    check_bit("insn_ready", insn_ready, 1'b0);
  endtask

  task automatic restart_core();
    tb_rst     = 1'b1;
    insn_valid = 1'b0;
    repeat (10) @(negedge clk);
    check_reset_state();
    tb_rst = 1'b0;
  endtask

  // core must stay stopped even with a word on offer
  task automatic check_stop(input logic ill);
    check_bit("halt", halt, 1'b1);
    check_bit("insn_ready", insn_ready, 1'b0);
    check_bit("illegal", illegal, ill);
    insn_valid = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check_bit("retire_valid", retire_valid, 1'b0);
    end
    insn_valid = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    int gap;
    gap        = $urandom % 4;
    insn_valid = 1'b0;
    repeat (gap) begin
      @(negedge clk);
      check_bit("retire_valid", retire_valid, 1'b0);
      check_word("fetch_pc", fetch_pc, r.pc);
    end
    wait_ready();
    if (!stop_run) begin
      check_word("fetch_pc", fetch_pc, r.pc);
      insn_valid = 1'b1;
      insn       = r.word;
      @(negedge clk);
      insn_valid = 1'b0;
      check_bit("retire_valid", retire_valid, 1'b1);
      check_bit("retire_rd_we", retire_rd_we, r.we != 0);
      if (r.we != 0) begin
        check_word("retire_rd", 32'(retire_rd), r.rd);
        check_word("retire_data", retire_data, r.data);
      end
      if (r.ends != END_NONE) begin
        check_stop(r.ends == END_ILLEGAL);
      end
    end
  endtask

  initial begin
    void'($urandom(32'hdcf6782f));
    insn_valid = 1'b0;
    insn       = '0;
    tb_rst     = 1'b0;
    errors     = 0;
    checks     = 0;
    stop_run   = 1'b0;
    build_table();
    @(negedge clk);
    wait_reset_release();
    if (!stop_run) begin
      check_reset_state();
    end
    for (int i = 0; i < rows.size() && !stop_run; i++) begin
      apply_row(rows[i]);
      if (rows[i].ends != END_NONE && i + 1 < rows.size()) begin
        restart_core();
      end
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end
endmodule

// File: flist.f
src/rv_isa_pkg.sv
src/core_cfg_pkg.sv
src/core_ifs.sv
src/insn_decode.sv
src/alu.sv
src/reg_file.sv
src/pc_unit.sv
src/rv_core.sv
bench/clk_gen.sv
bench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then grade run.log
rm -rf obj_dir run.log &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_rv_core \
  -f flist.f -o sim_tb && ./obj_dir/sim_tb > run.log 2>&1 || echo "build or run error"
grep -q '\*\*\* PASSED \*\*\*' run.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
